// ==== verilog.f ====
alu_pkg.sv
wb_regs_pkg.sv
alu_addsub.sv
alu_shift.sv
alu_top.sv
alu_wb_top.sv
tb_alu_wb_asserts.sv
tb_alu_wb.sv

// ==== tb_alu_wb.sv ====
`timescale 1ns/1ns
module tb_alu_wb;
  import alu_pkg::*;
  import wb_regs_pkg::*;

  localparam int XLEN        = 32;
  localparam int NUM_RANDOM  = 300;
  localparam int ACK_TIMEOUT = 20;

  logic             clk;
  logic             rst;
  logic             cyc;
  logic             stb;
  logic             we;
  logic [WB_AW-1:0] adr;
  logic [XLEN-1:0]  dat_w;
  logic [3:0]       sel;
  logic [XLEN-1:0]  dat_r;
  logic             ack;
  logic             err;

  logic [31:0] lfsr;      // random source state
  int          errors;
  int          checks;
  int          start_errs;
  logic [31:0] ra;
  logic [31:0] rb;
  logic [31:0] rr;
  logic [31:0] rf;
  logic [31:0] pick;
  logic [31:0] exp_word;
  alu_op_e     rop;

  alu_wb_top #(.XLEN(XLEN)) DUT (
    .clk_i (clk),
    .rst_i (rst),
    .cyc_i (cyc),
    .stb_i (stb),
    .we_i  (we),
    .adr_i (adr),
    .dat_i (dat_w),
    .sel_i (sel),
    .dat_o (dat_r),
    .ack_o (ack),
    .err_o (err)
  );

  always #2 clk = ~clk;

  // galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h80200003;
    return n;
  endfunction

  task automatic rand_bits(input int nbits, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};  // one step per bit
    end
  endtask

  // reference model returning {flag, result}
  function automatic logic [32:0] alu_model(input logic [31:0] a, input logic [31:0] b,
                                            input alu_op_e op);
    logic [31:0] res;
    logic        flag;
    logic [4:0]  sh;
    sh   = b[4:0];
    res  = '0;
    flag = 1'b0;
    case (op)
      ADD:        res = a + b;
      SUB:        res = a - b;
      XOR:        res = a ^ b;
      OR:         res = a | b;
      AND:        res = a & b;
      SLL:        res = a << sh;
      SRL:        res = a >> sh;
      SRA:        res = $signed(a) >>> sh;
      SLT, BLT:   flag = ($signed(a) < $signed(b));
      SLTU, BLTU: flag = (a < b);
      BEQ:        flag = (a == b);
      BNE:        flag = (a != b);
      BGE:        flag = ($signed(a) >= $signed(b));
      BGEU:       flag = (a >= b);
      default:    res = '0;
    endcase
    if (op >= SLT) res = {31'h0, flag};  // compare group returns the flag
    return {flag, res};
  endfunction

  task automatic bus_cycle(input logic write, input logic [WB_AW-1:0] addr,
                           input logic [31:0] wdata, input logic [3:0] sel_bits,
                           output logic [31:0] rdata, output logic got_ack,
                           output logic got_err);
    int   waited;
    logic done;
    @(posedge clk);
    #1;
    cyc     = 1'b1;
    stb     = 1'b1;
    we      = write;
    adr     = addr;
    dat_w   = wdata;
    sel     = sel_bits;
    waited  = 0;
    done    = 1'b0;
    rdata   = '0;
    got_ack = 1'b0;
    got_err = 1'b0;
    while (!done && waited < ACK_TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
      if (ack || err) begin
        done    = 1'b1;
        got_ack = ack;
        got_err = err;
        rdata   = dat_r;  // valid during the ack cycle only
      end
    end
    if (done) begin
      // strobe stays up until the edge that samples the answer
      @(posedge clk);
      #1;
    end
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    if (!done) begin
      $display("slave gave no ack or err within %0d cycles, address %h", ACK_TIMEOUT, addr);
      $display("*** TEST FAILED ***");
      $finish;
    end
  endtask

  task automatic write_reg(input logic [WB_AW-1:0] addr, input logic [31:0] data,
                           input logic [3:0] sel_bits);
    logic [31:0] unused;
    logic        a;
    logic        e;
    bus_cycle(1'b1, addr, data, sel_bits, unused, a, e);
    if (!a || e) begin
      errors++;
      $display("write to address %h was not acknowledged", addr);
    end
  endtask

  task automatic read_reg(input logic [WB_AW-1:0] addr, output logic [31:0] data);
    logic a;
    logic e;
    bus_cycle(1'b0, addr, '0, 4'h0, data, a, e);
    if (!a || e) begin
      errors++;
      $display("read of address %h was not acknowledged", addr);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // access that must end in err and never in ack
  task automatic expect_error(input logic write, input logic [WB_AW-1:0] addr);
    logic [31:0] unused;
    logic        a;
    logic        e;
    bus_cycle(write, addr, 32'hdeadbeef, 4'hf, unused, a, e);
    checks++;
    if (!e || a) begin
      errors++;
      $display("access to address %h did not end in err as it should", addr);
    end
  endtask

  // full round trip through the bus checked against the model
  task automatic run_op(input logic [31:0] a, input logic [31:0] b, input alu_op_e op,
                        output logic [31:0] res, output logic [31:0] flag);
    logic [32:0] exp;
    exp = alu_model(a, b, op);
    write_reg(REG_OPA, a, 4'hf);
    write_reg(REG_OPB, b, 4'hf);
    write_reg(REG_OP, {28'h0, op}, 4'hf);
    read_reg(REG_RESULT, res);
    read_reg(REG_FLAG, flag);
    check_word("result", res, exp[31:0]);
    check_word("flag", flag, {31'h0, exp[32]});
  endtask

  task automatic test_done(input string name, input int first_errs);
    $display("test %s finished with %0d errors", name, errors - first_errs);
  endtask

  initial begin
    clk    = 1'b0;
    rst    = 1'b1;
    cyc    = 1'b0;
    stb    = 1'b0;
    we     = 1'b0;
    adr    = '0;
    dat_w  = '0;
    sel    = '0;
    lfsr   = 32'hfdb0;
    errors = 0;
    checks = 0;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;

    start_errs = errors;
    read_reg(REG_OPA, rr);
    check_word("opa", rr, 32'h0);
    read_reg(REG_OPB, rr);
    check_word("opb", rr, 32'h0);
    read_reg(REG_OP, rr);
    check_word("op", rr, 32'h0);
    read_reg(REG_RESULT, rr);
    check_word("result", rr, 32'h0);  // add of two zeros
    test_done("reset_values", start_errs);

    start_errs = errors;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rand_bits(32, ra);
      rand_bits(32, rb);
      rand_bits(2, pick);
      if (pick[1:0] == 2'b00) rb = ra;  // equal operands now and then
      if (i < 16) begin
        rop = alu_op_e'(i[3:0]);  // every opcode at least once
      end else begin
        rand_bits(4, pick);
        rop = alu_op_e'(pick[3:0]);
      end
      run_op(ra, rb, rop, rr, rf);
    end
    test_done("random_ops", start_errs);

    start_errs = errors;
    run_op(32'h80000000, 32'h1, SLT, rr, rf);
    check_word("slt result", rr, 32'h1);
    run_op(32'h80000000, 32'h1, SLTU, rr, rf);
    check_word("sltu result", rr, 32'h0);
    run_op(32'h80000000, 32'h1, SUB, rr, rf);
    check_word("sub result", rr, 32'h7fffffff);
    run_op(32'h7fffffff, 32'hffffffff, SUB, rr, rf);
    check_word("sub result", rr, 32'h80000000);
    run_op(32'h80000010, 32'd31, SRA, rr, rf);
    check_word("sra result", rr, 32'hffffffff);
    run_op(32'h12345678, 32'h12345678, BEQ, rr, rf);
    check_word("beq flag", rf, 32'h1);
    run_op(32'h12345678, 32'h12345678, BNE, rr, rf);
    check_word("bne flag", rf, 32'h0);
    test_done("edge_cases", start_errs);

    start_errs = errors;
    for (int lane = 0; lane < 4; lane++) begin
      write_reg(REG_OPA, 32'h11223344, 4'hf);
      write_reg(REG_OPA, 32'haabbccdd, 4'h1 << lane);
      exp_word = 32'h11223344;
      exp_word[8*lane +: 8] = 8'hdd + 8'(lane) * 8'hef;  // dd, cc, bb, aa
      read_reg(REG_OPA, rr);
      check_word("opa", rr, exp_word);
    end
    write_reg(REG_OP, {28'h0, SRA}, 4'hf);
    write_reg(REG_OP, 32'h3, 4'he);  // lane 0 off so the opcode stays
    read_reg(REG_OP, rr);
    check_word("op", rr, {28'h0, SRA});
    test_done("byte_lanes", start_errs);

    start_errs = errors;
    write_reg(REG_OPA, 32'hcafe0001, 4'hf);
    write_reg(REG_OPB, 32'h00000005, 4'hf);
    write_reg(REG_OP, {28'h0, SLL}, 4'hf);
    expect_error(1'b0, 5'h14);
    expect_error(1'b1, 5'h1c);
    expect_error(1'b1, REG_RESULT);
    expect_error(1'b1, REG_FLAG);
    read_reg(REG_OPA, rr);
    check_word("opa", rr, 32'hcafe0001);
    read_reg(REG_OPB, rr);
    check_word("opb", rr, 32'h00000005);
    read_reg(REG_OP, rr);
    check_word("op", rr, {28'h0, SLL});
    read_reg(REG_RESULT, rr);
    check_word("result", rr, 32'h5fc00020);
    test_done("bus_errors", start_errs);

    if (DUT.u_wb_asserts.fail_count != 0) begin
      errors += DUT.u_wb_asserts.fail_count;
      $display("bus protocol assertions failed %0d times", DUT.u_wb_asserts.fail_count);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== tb_alu_wb_asserts.sv ====
`timescale 1ns/1ns
module tb_alu_wb_asserts (
  input logic clk_i,
  input logic rst_i,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic err_i
);

  int fail_count = 0;  // count of failed assertions

  // never both answers in one cycle
  ack_err_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(ack_i && err_i))
    else begin
      fail_count++;
      $error("ack and err high in the same cycle");
    end

  ack_single_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_i |=> !ack_i)
    else begin
      fail_count++;
      $error("ack held for more than one cycle");
    end

  // ack answers a strobe seen one edge earlier
  ack_after_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_i |-> $past(cyc_i && stb_i))
    else begin
      fail_count++;
      $error("ack without a strobe in the previous cycle");
    end

endmodule

bind alu_wb_top tb_alu_wb_asserts u_wb_asserts (
  .clk_i (clk_i),
  .rst_i (rst_i),
  .cyc_i (cyc_i),
  .stb_i (stb_i),
  .ack_i (ack_o),
  .err_i (err_o)
);

// ==== alu_wb_top.sv ====
`timescale 1ns/1ns
module alu_wb_top #(
  parameter int XLEN = 32
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        cyc_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic [wb_regs_pkg::WB_AW-1:0] adr_i,
  input  logic [XLEN-1:0]             dat_i,
  input  logic [XLEN/8-1:0]           sel_i,
  output logic [XLEN-1:0]             dat_o,
  output logic                        ack_o,
  output logic                        err_o
);
  import alu_pkg::*;
  import wb_regs_pkg::*;

  localparam int SELW = XLEN / 8;

  logic [XLEN-1:0]      opa_q;
  logic [XLEN-1:0]      opb_q;
  alu_op_e              op_q;
  logic [ALUOP_LEN-1:0] op_bits;
  logic [XLEN-1:0]      alu_res;
  logic                 cmp_flag;
  logic [XLEN-1:0]      rd_mux;
  logic [XLEN-1:0]      rd_q;
  logic                 valid;
  logic                 mapped;
  logic                 read_only;
  logic                 bad;

  // new transfer, not the tail of the previous one
  assign valid = cyc_i & stb_i & ~ack_o & ~err_o;

  always_comb begin
    mapped    = 1'b1;
    read_only = 1'b0;
    case (adr_i)
      REG_OPA, REG_OPB, REG_OP: read_only = 1'b0;
      REG_RESULT, REG_FLAG:     read_only = 1'b1;
      default:                  mapped = 1'b0;
    endcase
  end

  assign bad = ~mapped | (we_i & read_only);

  // read data from the registers as they are now
  always_comb begin
    case (adr_i)
      REG_OPA:    rd_mux = opa_q;
      REG_OPB:    rd_mux = opb_q;
      REG_OP:     rd_mux = {{(XLEN-ALUOP_LEN){1'b0}}, op_q};
      REG_RESULT: rd_mux = alu_res;
      REG_FLAG:   rd_mux = {{(XLEN-1){1'b0}}, cmp_flag};
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
      opa_q <= '0;
      opb_q <= '0;
      op_q  <= ADD;
    end else begin
      ack_o <= valid & ~bad;
      err_o <= valid & bad;
      if (valid & we_i & ~bad) begin
        for (int i = 0; i < SELW; i++) begin
          if (sel_i[i] && adr_i == REG_OPA) opa_q[8*i +: 8] <= dat_i[8*i +: 8];
          if (sel_i[i] && adr_i == REG_OPB) opb_q[8*i +: 8] <= dat_i[8*i +: 8];
        end
        if (sel_i[0] && adr_i == REG_OP) op_q <= alu_op_e'(dat_i[ALUOP_LEN-1:0]);
      end
    end
  end

  // captured on the request edge, shown during ack
  always_ff @(posedge clk_i) begin
    if (valid) rd_q <= we_i ? '0 : rd_mux;
  end

  assign dat_o = ack_o ? rd_q : '0;

  assign op_bits = op_q;

  alu_top #(.XLEN(XLEN)) u_alu (
    .alu_a_i       (opa_q),
    .alu_b_i       (opb_q),
    .alu_op_i      (op_bits),
    .alu_out_o     (alu_res),
    .compare_out_o (cmp_flag)
  );

endmodule

// ==== alu_top.sv ====
`timescale 1ns/1ns
module alu_top #(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0]               alu_a_i,
  input  logic [XLEN-1:0]               alu_b_i,
  input  logic [alu_pkg::ALUOP_LEN-1:0] alu_op_i,
  output logic [XLEN-1:0]               alu_out_o,
  output logic                          compare_out_o
);
  import alu_pkg::*;

  localparam int SHW = $clog2(XLEN);

  alu_op_e         op;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] shift_res;
  logic [XLEN-1:0] logic_res;
  logic            cmp_flag;
  logic            is_arith;
  logic            is_logic;
  logic            is_shift;

  assign op = alu_op_e'(alu_op_i);

  alu_addsub #(.XLEN(XLEN)) u_addsub (
    .alu_a_i   (alu_a_i),
    .alu_b_i   (alu_b_i),
    .alu_op_i  (op),
    .sum_o     (sum),
    .compare_o (cmp_flag)
  );

  alu_shift #(.XLEN(XLEN)) u_shift (
    .alu_a_i     (alu_a_i),
    .shamt_i     (alu_b_i[SHW-1:0]),  // low bits of b only
    .alu_op_i    (op),
    .shift_out_o (shift_res)
  );

  always_comb begin
    case (op)
      XOR:     logic_res = alu_a_i ^ alu_b_i;
      OR:      logic_res = alu_a_i | alu_b_i;
      AND:     logic_res = alu_a_i & alu_b_i;
      default: logic_res = '0;
    endcase
  end

  // operation classes
  assign is_arith = (op == ADD) | (op == SUB);
  assign is_logic = (op == XOR) | (op == OR) | (op == AND);
  assign is_shift = (op == SLL) | (op == SRL) | (op == SRA);

  always_comb begin
    if (is_arith) alu_out_o = sum;
    else if (is_logic) alu_out_o = logic_res;
    else if (is_shift) alu_out_o = shift_res;
    else alu_out_o = {{(XLEN-1){1'b0}}, cmp_flag};  // compare group gives the flag as 0 or 1
  end

  assign compare_out_o = cmp_flag;

endmodule

// ==== alu_shift.sv ====
`timescale 1ns/1ns
module alu_shift #(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0]         alu_a_i,
  input  logic [$clog2(XLEN)-1:0] shamt_i,
  input  alu_pkg::alu_op_e        alu_op_i,
  output logic [XLEN-1:0]         shift_out_o
);
  import alu_pkg::*;

  localparam int SHW = $clog2(XLEN);

  logic            fill;
  logic [XLEN-1:0] rev_a;
  logic [XLEN-1:0] stage [SHW+1];

  function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] v);
    logic [XLEN-1:0] r;
    for (int i = 0; i < XLEN; i++) begin
      r[i] = v[XLEN-1-i];
    end
    return r;
  endfunction

  assign rev_a = bit_rev(alu_a_i);

  // sign fill only for arithmetic right shift
  assign fill = (alu_op_i == SRA) & alu_a_i[XLEN-1];

  // left shift runs through the right shifter on reversed bits
  assign stage[0] = (alu_op_i == SLL) ? rev_a : alu_a_i;

  for (genvar s = 0; s < SHW; s++) begin : g_stage
    localparam int STEP = 1 << s;
    assign stage[s+1] = shamt_i[s] ? {{STEP{fill}}, stage[s][XLEN-1:STEP]} : stage[s];
  end

  always_comb begin
    case (alu_op_i)
      SLL:      shift_out_o = bit_rev(stage[SHW]);  // back to normal order
      SRL, SRA: shift_out_o = stage[SHW];
      default:  shift_out_o = '0;
    endcase
  end

endmodule

// ==== alu_addsub.sv ====
`timescale 1ns/1ns
module alu_addsub #(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0]  alu_a_i,
  input  logic [XLEN-1:0]  alu_b_i,
  input  alu_pkg::alu_op_e alu_op_i,
  output logic [XLEN-1:0]  sum_o,
  output logic             compare_o
);
  import alu_pkg::*;

  logic            is_cmp;
  logic            is_sub;
  logic [XLEN:0]   a_ext;
  logic [XLEN:0]   b_ext;
  logic [XLEN:0]   sum_ext;
  logic            carry_top;  // carry into the extension bit
  logic            zero_f;
  logic            ovf_f;
  logic            sign_f;
  logic            carry_f;
  logic            lt_s;
  logic            lt_u;

  // compare group
  always_comb begin
    case (alu_op_i)
      SLT, SLTU, BEQ, BNE, BLT, BGE, BLTU, BGEU: is_cmp = 1'b1;
      default: is_cmp = 1'b0;
    endcase
  end

  assign is_sub = (alu_op_i == SUB) | is_cmp;

  // one extra sign bit on both operands
  assign a_ext = {alu_a_i[XLEN-1], alu_a_i};
  assign b_ext = {alu_b_i[XLEN-1], alu_b_i} ^ {(XLEN+1){is_sub}};  // invert for subtract

  // a + b, or a + ~b + 1
  assign sum_ext = a_ext + b_ext + {{XLEN{1'b0}}, is_sub};

  assign sum_o = sum_ext[XLEN-1:0];

  // carry out of the plain XLEN-bit add, recovered from the top bit
  assign carry_top = a_ext[XLEN] ^ b_ext[XLEN] ^ sum_ext[XLEN];

  assign zero_f  = (sum_ext == '0);
  assign ovf_f   = sum_ext[XLEN] ^ sum_ext[XLEN-1];
  assign sign_f  = sum_ext[XLEN-1];
  assign carry_f = is_sub ^ carry_top;  // borrow when subtracting

  assign lt_s = sign_f ^ ovf_f;
  assign lt_u = carry_f;

  // pick the flag the opcode asks for
  always_comb begin
    case (alu_op_i)
      SLT, BLT:   compare_o = lt_s;
      SLTU, BLTU: compare_o = lt_u;
      BGE:        compare_o = ~lt_s;
      BGEU:       compare_o = ~lt_u;
      BEQ:        compare_o = zero_f;
      BNE:        compare_o = ~zero_f;
      default:    compare_o = 1'b0;  // not a compare
    endcase
  end

endmodule

// ==== wb_regs_pkg.sv ====
package wb_regs_pkg;

  // byte address width of the slave port
  localparam int WB_AW = 5;

  // register map in byte offsets
  localparam logic [WB_AW-1:0] REG_OPA    = 5'h00;  // rw operand a
  localparam logic [WB_AW-1:0] REG_OPB    = 5'h04;  // rw operand b
  localparam logic [WB_AW-1:0] REG_OP     = 5'h08;  // rw opcode in bits 3:0

  // read-only results of the ALU
  localparam logic [WB_AW-1:0] REG_RESULT = 5'h0C;
  localparam logic [WB_AW-1:0] REG_FLAG   = 5'h10;  // compare flag in bit 0

  // any other offset is answered with err

endpackage

// ==== alu_pkg.sv ====
package alu_pkg;

  // opcode field width as stored in the REG_OP register
  localparam int ALUOP_LEN = 4;

  // operation codes numbered in this order from 0
  typedef enum logic [ALUOP_LEN-1:0] {
    // arithmetic
    ADD,
    SUB,
    // bitwise logic
    XOR,
    OR,
    AND,
    // shifts by the low bits of operand b
    SLL,
    SRL,
    SRA,
    // set-less-than with the flag as result
    SLT,
    SLTU,
    // branch conditions
    BEQ,
    BNE,
    BLT,   // signed a < b
    BGE,   // signed a >= b
    BLTU,  // unsigned a < b
    BGEU   // unsigned a >= b
  } alu_op_e;

  // every code in the field is used, so any 4-bit value is a legal opcode
  // the compare group goes through the subtract path of the adder
  // and leaves its answer on the flag output

endpackage
